//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       := tb_decode_top
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- branch_check.sv
module branch_check (
    input  logic                        cpu_clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    input  logic                        accept_i,       // bundle register captures
    input  decode_pkg::bundle_info_t    info_i,
    input  logic [1:0]                  slot_branch_i,
    input  logic                        icache_idle_i,
    input  logic                        rn_busy_i,
    output logic                        slot1_valid_o,
    output logic                        drop_bundle_o,
    output logic                        branch_correction_flush_o,
    output logic [decode_pkg::PC_W-1:0] branch_correction_pc_o
);
    import decode_pkg::*;

    logic            slot0_taken;
    logic [1:0]      br_decoded;
    logic [1:0]      br_predicted;
    logic            needs_fix;
    logic            hold_q;
    logic [PC_W-1:0] fix_pc_q;

    assign slot0_taken = info_i.btb.vld && !info_i.btb.idx
                      && info_i.btb.target != info_i.pc + PC_W'(1)
                      && (info_i.btb.btype != 2'b00 || info_i.btb.bm_pred[1]);
    assign slot1_valid_o = !info_i.pc[0] && !slot0_taken;

    assign br_decoded   = {slot_branch_i[1] && slot1_valid_o, slot_branch_i[0]};
    assign br_predicted = {info_i.btb.vld && info_i.btb.idx && slot1_valid_o,
                           info_i.btb.vld && !info_i.btb.idx};
    assign needs_fix    = |(br_predicted & ~br_decoded);  // prediction on a non-branch

    assign drop_bundle_o             = hold_q || needs_fix;
    assign branch_correction_flush_o = hold_q && icache_idle_i && !flush_i && !rn_busy_i;
    assign branch_correction_pc_o    = fix_pc_q;

    always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hold_q <= 1'b0;
        end else if (flush_i || branch_correction_flush_o) begin
            hold_q <= 1'b0;
        end else if (accept_i && needs_fix) begin
            hold_q <= 1'b1;  // front end stalls until the refetch
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (accept_i && needs_fix && !hold_q) begin
            fix_pc_q <= info_i.pc;
        end
    end

    // the bundle register must not capture alongside a correction flush
    a_no_accept_on_flush: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        branch_correction_flush_o |-> !accept_i);

endmodule

//--- decode_bundle_reg.sv
module decode_bundle_reg (
    input  logic                     cpu_clk_i,
    input  logic                     rst_n_i,
    input  logic                     clear_i,
    input  logic                     in_valid_i,
    input  logic                     rn_busy_i,
    input  logic                     drop_i,
    input  decode_pkg::uop_t         uop0_i,
    input  decode_pkg::uop_t         uop1_i,
    input  decode_pkg::bundle_info_t info_i,
    output logic                     valid_o,
    output decode_pkg::uop_t         ins0_o,
    output decode_pkg::uop_t         ins1_o,
    output decode_pkg::bundle_info_t bundle_o,
    output logic                     accept_o
);
    assign accept_o = in_valid_i && !rn_busy_i && !clear_i;

    always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else if (clear_i) begin
            valid_o <= 1'b0;
        end else if (!rn_busy_i) begin
            valid_o <= in_valid_i && !drop_i;  // dropped bundles leave invalid
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (accept_o) begin
            ins0_o   <= uop0_i;
            ins1_o   <= uop1_i;
            bundle_o <= info_i;
        end
    end

endmodule

//--- decode_pkg.sv
package decode_pkg;

    localparam int INSN_W    = 32;
    localparam int PC_W      = 30;  // word address
    localparam int IMM_W     = 32;
    localparam int REG_IDX_W = 5;
    localparam int EXC_W     = 4;

    // major opcodes, insn[6:2]
    localparam logic [4:0] OPC_LOAD     = 5'b00000;
    localparam logic [4:0] OPC_MISC_MEM = 5'b00011;
    localparam logic [4:0] OPC_OP_IMM   = 5'b00100;
    localparam logic [4:0] OPC_AUIPC    = 5'b00101;
    localparam logic [4:0] OPC_STORE    = 5'b01000;
    localparam logic [4:0] OPC_OP       = 5'b01100;
    localparam logic [4:0] OPC_LUI      = 5'b01101;
    localparam logic [4:0] OPC_BRANCH   = 5'b11000;
    localparam logic [4:0] OPC_JALR     = 5'b11001;
    localparam logic [4:0] OPC_JAL      = 5'b11011;
    localparam logic [4:0] OPC_SYSTEM   = 5'b11100;

    localparam logic [EXC_W-1:0] EXC_ILLEGAL = 4'd2;
    localparam logic [EXC_W-1:0] EXC_BREAK   = 4'd3;
    localparam logic [EXC_W-1:0] EXC_ECALL_U = 4'd8;
    localparam logic [EXC_W-1:0] EXC_ECALL_M = 4'd11;

    typedef struct packed {
        logic [PC_W-1:0] target;
        logic [1:0]      btype;    // 00 cond, 01 indirect, 10 jump, 11 return
        logic [1:0]      bm_pred;  // bimodal counter
        logic            vld;
        logic            idx;      // slot the prediction belongs to
        logic            way;
    } btb_info_t;

    typedef struct packed {
        logic [2*INSN_W-1:0] insn;
        logic [PC_W-1:0]     pc;
        btb_info_t           btb;
        logic                excp_vld;
        logic [EXC_W-1:0]    excp_code;
    } fetch_packet_t;

    typedef struct packed {
        logic                 port;        // 1 = in-order scheduler
        logic                 dnagn;       // no rename allocation
        logic [4:0]           alu_type;    // auipc, lui, jalr, jal, alu
        logic [6:0]           alu_opcode;
        logic                 alu_imm;
        logic [4:0]           ios_type;    // load, store, csr, fence, muldiv
        logic [2:0]           ios_opcode;
        logic [3:0]           special;     // csr write, mret, fence.i, wfi
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] dest;
        logic [IMM_W-1:0]     imm;
        logic [2:0]           reg_props;   // writes rd, reads rs1, reads rs2
        logic                 dnr;         // csr immediate form, no rs1 read
        logic                 mov_elim;
        logic                 excp_valid;
        logic [EXC_W-1:0]     excp_code;
    } uop_t;

    typedef struct packed {
        logic [PC_W-1:0] pc;
        btb_info_t       btb;
        logic            slot1_valid;
    } bundle_info_t;

endpackage

//--- decode_top.sv
module decode_top (
    input  logic                        cpu_clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    input  logic                        priv_m_i,
    input  logic                        tw_i,
    input  logic                        icache_idle_i,
    input  logic                        fetch_valid_i,
    input  decode_pkg::fetch_packet_t   fetch_pkt_i,
    output logic                        busy_o,
    input  logic                        rn_busy_i,
    output logic                        valid_o,
    output decode_pkg::uop_t            ins0_o,
    output decode_pkg::uop_t            ins1_o,
    output decode_pkg::bundle_info_t    bundle_o,
    output logic                        branch_correction_flush_o,
    output logic [decode_pkg::PC_W-1:0] branch_correction_pc_o
);
    import decode_pkg::*;

    fetch_packet_t     buf_pkt;
    logic              buf_valid;
    logic              buf_clear;
    logic [INSN_W-1:0] insn0;
    logic [INSN_W-1:0] insn1;
    uop_t              uop0;
    uop_t              uop1;
    logic [1:0]        slot_branch;
    logic              slot1_valid;
    logic              drop_bundle;
    logic              accept;
    bundle_info_t      chk_info;
    bundle_info_t      reg_info;

    assign buf_clear = flush_i || branch_correction_flush_o;
    assign insn0     = buf_pkt.pc[0] ? buf_pkt.insn[2*INSN_W-1:INSN_W] : buf_pkt.insn[INSN_W-1:0];
    assign insn1     = buf_pkt.insn[2*INSN_W-1:INSN_W];
    assign chk_info  = '{pc: buf_pkt.pc, btb: buf_pkt.btb, slot1_valid: 1'b0};
    assign reg_info  = '{pc: buf_pkt.pc, btb: buf_pkt.btb, slot1_valid: slot1_valid};

    fetch_skid_buffer #(.payload_t(fetch_packet_t)) u_skid (
        .cpu_clk_i   (cpu_clk_i),
        .rst_n_i     (rst_n_i),
        .clear_i     (buf_clear),
        .in_valid_i  (fetch_valid_i),
        .in_data_i   (fetch_pkt_i),
        .out_ready_i (!rn_busy_i),
        .out_valid_o (buf_valid),
        .out_data_o  (buf_pkt),
        .busy_o      (busy_o)
    );

    rv_slot_decoder u_dec0 (
        .insn_i             (insn0),
        .priv_m_i           (priv_m_i),
        .tw_i               (tw_i),
        .fetch_excp_valid_i (buf_pkt.excp_vld),
        .fetch_excp_code_i  (buf_pkt.excp_code),
        .uop_o              (uop0),
        .is_branch_o        (slot_branch[0])
    );

    rv_slot_decoder u_dec1 (
        .insn_i             (insn1),
        .priv_m_i           (priv_m_i),
        .tw_i               (tw_i),
        .fetch_excp_valid_i (buf_pkt.excp_vld),
        .fetch_excp_code_i  (buf_pkt.excp_code),
        .uop_o              (uop1),
        .is_branch_o        (slot_branch[1])
    );

    branch_check u_bchk (
        .cpu_clk_i                 (cpu_clk_i),
        .rst_n_i                   (rst_n_i),
        .flush_i                   (flush_i),
        .accept_i                  (accept),
        .info_i                    (chk_info),
        .slot_branch_i             (slot_branch),
        .icache_idle_i             (icache_idle_i),
        .rn_busy_i                 (rn_busy_i),
        .slot1_valid_o             (slot1_valid),
        .drop_bundle_o             (drop_bundle),
        .branch_correction_flush_o (branch_correction_flush_o),
        .branch_correction_pc_o    (branch_correction_pc_o)
    );

    decode_bundle_reg u_breg (
        .cpu_clk_i  (cpu_clk_i),
        .rst_n_i    (rst_n_i),
        .clear_i    (buf_clear),
        .in_valid_i (buf_valid),
        .rn_busy_i  (rn_busy_i),
        .drop_i     (drop_bundle),
        .uop0_i     (uop0),
        .uop1_i     (uop1),
        .info_i     (reg_info),
        .valid_o    (valid_o),
        .ins0_o     (ins0_o),
        .ins1_o     (ins1_o),
        .bundle_o   (bundle_o),
        .accept_o   (accept)
    );

endmodule

//--- fetch_skid_buffer.sv
module fetch_skid_buffer #(
    parameter type payload_t = logic
) (
    input  logic     cpu_clk_i,
    input  logic     rst_n_i,
    input  logic     clear_i,
    input  logic     in_valid_i,
    input  payload_t in_data_i,
    input  logic     out_ready_i,
    output logic     out_valid_o,
    output payload_t out_data_o,
    output logic     busy_o
);
    payload_t skid_data_q;
    logic     skid_valid_q;
    logic     push;
    logic     pop;
    logic     main_load;
    logic     skid_load;

    assign busy_o    = skid_valid_q;
    assign push      = in_valid_i && !skid_valid_q;
    assign pop       = out_valid_o && out_ready_i;
    assign main_load = !out_valid_o || pop;     // main register free this cycle
    assign skid_load = push && !main_load;       // consumer stalled, park the packet

    always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_o  <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (clear_i) begin
            out_valid_o  <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (main_load) begin
            out_valid_o  <= skid_valid_q || push;
            skid_valid_q <= 1'b0;
        end else if (skid_load) begin
            skid_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (main_load) begin
            out_data_o <= skid_valid_q ? skid_data_q : in_data_i;  // oldest first
        end
        if (skid_load) begin
            skid_data_q <= in_data_i;
        end
    end

    // a parked packet always sits behind a full main register
    a_skid_behind_main: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        skid_valid_q |-> out_valid_o);

endmodule

//--- rv_slot_decoder.sv
module rv_slot_decoder (
    input  logic [decode_pkg::INSN_W-1:0] insn_i,
    input  logic                          priv_m_i,  // 1 = machine mode
    input  logic                          tw_i,
    input  logic                          fetch_excp_valid_i,
    input  logic [decode_pkg::EXC_W-1:0]  fetch_excp_code_i,
    output decode_pkg::uop_t              uop_o,
    output logic                          is_branch_o
);
    import decode_pkg::*;

    logic [4:0]           opc;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [REG_IDX_W-1:0] rd;
    logic is_load, is_store, is_system, is_branch, is_jal, is_jalr;
    logic is_auipc, is_lui, is_op, is_op_imm, is_md, is_shift;
    logic is_ecall, is_ebreak, is_sret, is_mret, is_wfi, is_sfence, is_csr;
    logic is_fence, is_fence_i;
    logic op_ok, op_imm_ok, sys_ok, legal;
    logic mret_bad, wfi_bad, decode_excp;
    logic [IMM_W-1:0] imm_i, imm_s, imm_u, imm_j, imm_b, imm_sel;
    logic [6:0]       alu_op;
    logic [EXC_W-1:0] decode_code;

    assign opc    = insn_i[6:2];
    assign funct3 = insn_i[14:12];
    assign funct7 = insn_i[31:25];
    assign rd     = insn_i[11:7];

    assign is_load   = opc == OPC_LOAD;
    assign is_store  = opc == OPC_STORE;
    assign is_system = opc == OPC_SYSTEM;
    assign is_branch = opc == OPC_BRANCH;
    assign is_jal    = opc == OPC_JAL;
    assign is_jalr   = opc == OPC_JALR;
    assign is_auipc  = opc == OPC_AUIPC;
    assign is_lui    = opc == OPC_LUI;
    assign is_op     = opc == OPC_OP;
    assign is_op_imm = opc == OPC_OP_IMM;
    assign is_md     = is_op && funct7 == 7'b0000001;
    assign is_shift  = funct3[1:0] == 2'b01;

    // system space, everything above the opcode is fixed except for csr ops
    assign is_ecall  = is_system && insn_i[31:7] == 25'h0000000;
    assign is_ebreak = is_system && insn_i[31:7] == 25'h0002000;
    assign is_sret   = is_system && insn_i[31:7] == 25'h0204000;
    assign is_mret   = is_system && insn_i[31:7] == 25'h0604000;
    assign is_wfi    = is_system && insn_i[31:7] == 25'h020a000;
    assign is_sfence = is_system && funct7 == 7'b0001001 && funct3 == 3'b000;
    assign is_csr    = is_system && funct3[1:0] != 2'b00;

    assign is_fence   = insn_i[19:0] == 20'h0000f && opc == OPC_MISC_MEM;
    assign is_fence_i = insn_i == 32'h0000100f;

    assign op_ok = funct7 == 7'b0000000 || funct7 == 7'b0000001
                || (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
    assign op_imm_ok = !is_shift || funct7 == 7'b0000000
                    || (funct7 == 7'b0100000 && funct3 == 3'b101);  // srai
    assign sys_ok = is_ecall || is_ebreak || is_sret || is_mret || is_wfi
                 || is_sfence || is_csr;

    assign legal = insn_i[1:0] == 2'b11
        && (is_auipc || is_lui || is_jal || is_jalr || (is_op && op_ok)
            || (is_op_imm && op_imm_ok)
            || (is_branch && funct3[2:1] != 2'b01)
            || (is_load && funct3[2:1] != 2'b11)
            || (is_store && funct3 <= 3'b010)
            || sys_ok || is_fence || is_fence_i);

    assign mret_bad    = is_mret && !priv_m_i;
    assign wfi_bad     = is_wfi && !priv_m_i && tw_i;
    assign decode_excp = !legal || mret_bad || wfi_bad || is_ecall || is_ebreak;

    always_comb begin
        if (!legal || mret_bad || wfi_bad) begin
            decode_code = EXC_ILLEGAL;
        end else if (is_ecall) begin
            decode_code = priv_m_i ? EXC_ECALL_M : EXC_ECALL_U;
        end else begin
            decode_code = EXC_BREAK;
        end
    end

    assign imm_i = {{20{insn_i[31]}}, insn_i[31:20]};
    assign imm_s = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
    assign imm_u = {insn_i[31:12], 12'h000};
    assign imm_j = {{12{insn_i[31]}}, insn_i[19:12], insn_i[20], insn_i[30:21], 1'b0};
    assign imm_b = {{20{insn_i[31]}}, insn_i[7], insn_i[30:25], insn_i[11:8], 1'b0};

    always_comb begin
        if (is_op_imm || is_jalr || is_load || is_system) begin
            imm_sel = imm_i;
        end else if (is_store) begin
            imm_sel = imm_s;
        end else if (is_lui || is_auipc) begin
            imm_sel = imm_u;
        end else if (is_jal) begin
            imm_sel = imm_j;
        end else if (is_branch) begin
            imm_sel = imm_b;
        end else begin
            imm_sel = '0;
        end
    end

    always_comb begin
        if (is_op) begin
            alu_op = {3'b000, funct7[5], funct3};
        end else if (is_op_imm) begin
            alu_op = {3'b000, is_shift && funct7[5], funct3};  // bit 30 only on shifts
        end else begin
            alu_op = {4'b0000, funct3};
        end
    end

    always_comb begin
        uop_o.ios_type   = {is_load, is_store, is_csr, is_fence, is_md};
        uop_o.port       = |uop_o.ios_type;
        uop_o.dnagn      = is_fence_i || is_mret || is_wfi;
        uop_o.alu_type   = {is_auipc, is_lui, is_jalr, is_jal, (is_op && !is_md) || is_op_imm};
        uop_o.alu_opcode = alu_op;
        uop_o.alu_imm    = is_op_imm;
        uop_o.ios_opcode = funct3;
        uop_o.special    = {is_csr && (insn_i[19:15] != '0 || funct3[2]), is_mret,
                            is_fence_i, is_wfi};
        uop_o.rs1        = insn_i[19:15];
        uop_o.rs2        = insn_i[24:20];
        uop_o.dest       = rd;
        uop_o.imm        = imm_sel;
        uop_o.reg_props  = {(is_op || is_op_imm || is_load || is_jal || is_jalr || is_auipc
                             || is_lui || is_csr) && rd != '0,
                            !(is_ecall || is_ebreak || is_sret || is_mret || is_wfi
                              || is_sfence || is_auipc || is_lui || is_jal),
                            is_op || is_branch || is_store};
        uop_o.dnr        = is_csr && funct3[2];
        uop_o.mov_elim   = is_op_imm && funct3 == 3'b000 && insn_i[31:20] == 12'h000;
        uop_o.excp_valid = fetch_excp_valid_i || decode_excp;
        uop_o.excp_code  = fetch_excp_valid_i ? fetch_excp_code_i : decode_code;
    end

    assign is_branch_o = is_jal || is_jalr || is_branch;

endmodule

//--- sources.f
+incdir+.
decode_pkg.sv
fetch_skid_buffer.sv
rv_slot_decoder.sv
branch_check.sv
decode_bundle_reg.sv
decode_top.sv
tb_decode_top.sv

//--- tb_decode_table.svh
`ifndef TB_DECODE_TABLE_SVH
`define TB_DECODE_TABLE_SVH

typedef struct packed {
    logic [2*INSN_W-1:0] insn;       // {slot 1 word, slot 0 word}
    logic [PC_W-1:0]     pc;
    btb_info_t           btb;
    logic                priv_m;
    logic                tw;
    logic                fx_vld;     // fetch exception
    logic [EXC_W-1:0]    fx_code;
    uop_t                exp0;
    uop_t                exp1;
    logic                exp_s1v;
    logic                exp_valid;
} row_t;

localparam btb_info_t BTB_NONE = '{'0, '0, '0, '0, '0, '0};
localparam btb_info_t BTB_BEQ  = '{30'd80, 2'd0, 2'd3, '1, '0, '0};   // taken cond on slot 0
localparam btb_info_t BTB_FIX  = '{30'd200, 2'd2, '0, '1, '0, '0};    // jump on a non-branch

// port dnagn alu_type alu_op alu_imm ios_type ios_op special rs1 rs2 dest imm props dnr mv exc
localparam uop_t U_ADD  = '{'0, '0, 5'h01, '0, '0, '0, '0, '0, 5'd1, 5'd2, 5'd3, '0,
                            3'b111, '0, '0, '0, '0};
localparam uop_t U_SUB  = '{'0, '0, 5'h01, 7'h08, '0, '0, '0, '0, 5'd6, 5'd7, 5'd5, '0,
                            3'b111, '0, '0, '0, '0};
localparam uop_t U_LW   = '{'1, '0, '0, 7'h02, '0, 5'h10, 3'd2, '0, 5'd2, 5'd28, 5'd10,
                            32'hffff_fffc, 3'b110, '0, '0, '0, '0};
localparam uop_t U_SW   = '{'1, '0, '0, 7'h02, '0, 5'h08, 3'd2, '0, 5'd1, 5'd5, 5'd8, 32'd8,
                            3'b011, '0, '0, '0, '0};
localparam uop_t U_MV   = '{'0, '0, 5'h01, '0, '1, '0, '0, '0, 5'd2, '0, 5'd1, '0,
                            3'b110, '0, '1, '0, '0};
localparam uop_t U_MUL  = '{'1, '0, '0, '0, '0, 5'h01, '0, '0, 5'd1, 5'd2, 5'd3, '0,
                            3'b111, '0, '0, '0, '0};
localparam uop_t U_CSR  = '{'1, '0, '0, 7'h01, '0, 5'h04, 3'd1, 4'b1000, 5'd2, '0, 5'd1,
                            32'h300, 3'b110, '0, '0, '0, '0};
localparam uop_t U_JAL  = '{'0, '0, 5'h02, '0, '0, '0, '0, '0, '0, 5'd8, 5'd1, 32'd8,
                            3'b100, '0, '0, '0, '0};
localparam uop_t U_BEQ  = '{'0, '0, '0, '0, '0, '0, '0, '0, 5'd1, 5'd2, 5'd16, 32'd16,
                            3'b011, '0, '0, '0, '0};
localparam uop_t U_NOP  = '{'0, '0, 5'h01, '0, '1, '0, '0, '0, '0, '0, '0, '0,
                            3'b010, '0, '1, '0, '0};
localparam uop_t U_ECU  = '{'0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '1, 4'd8};
localparam uop_t U_ECM  = '{'0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '1, 4'd11};
localparam uop_t U_MRET = '{'0, '1, '0, '0, '0, '0, '0, 4'b0100, '0, 5'd2, '0, 32'h302,
                            '0, '0, '0, '1, 4'd2};
localparam uop_t U_WFI  = '{'0, '1, '0, '0, '0, '0, '0, 4'b0001, '0, 5'd5, '0, 32'h105,
                            '0, '0, '0, '1, 4'd2};
localparam uop_t U_ILL  = '{'1, '0, '0, '0, '0, 5'h10, '0, '0, '0, '0, '0, '0,
                            3'b010, '0, '0, '1, 4'd2};
localparam uop_t U_EBRK = '{'0, '0, '0, '0, '0, '0, '0, '0, '0, 5'd1, '0, 32'h1,
                            '0, '0, '0, '1, 4'd3};

localparam int NUM_ROWS = 14;
localparam logic [2*INSN_W-1:0] NOP_PAIR = 64'h00000013_00000013;

row_t rows [NUM_ROWS] = '{
    '{64'h407302b3_002081b3, 30'd64, BTB_NONE, '0, '0, '0, '0, U_ADD, U_SUB, '1, '1},
    '{64'h0050a423_ffc12503, 30'd66, BTB_NONE, '0, '0, '0, '0, U_LW, U_SW, '1, '1},
    '{64'h022081b3_00010093, 30'd68, BTB_NONE, '0, '0, '0, '0, U_MV, U_MUL, '1, '1},
    '{64'h008000ef_300110f3, 30'd70, BTB_NONE, '1, '0, '0, '0, U_CSR, U_JAL, '1, '1},
    '{64'h00000013_00208863, 30'd72, BTB_BEQ, '0, '0, '0, '0, U_BEQ, U_NOP, '0, '1},
    '{64'h00000013_00000073, 30'd74, BTB_NONE, '0, '0, '0, '0, U_ECU, U_NOP, '1, '1},
    '{64'h00000013_00000073, 30'd76, BTB_NONE, '1, '0, '0, '0, U_ECM, U_NOP, '1, '1},
    '{64'h00000013_30200073, 30'd78, BTB_NONE, '0, '0, '0, '0, U_MRET, U_NOP, '1, '1},
    '{64'h00000013_10500073, 30'd80, BTB_NONE, '0, '1, '0, '0, U_WFI, U_NOP, '1, '1},
    '{64'h00000013_00000000, 30'd82, BTB_NONE, '0, '0, '0, '0, U_ILL, U_NOP, '1, '1},
    '{64'h00000013_00100073, 30'd84, BTB_NONE, '0, '0, '0, '0, U_EBRK, U_NOP, '1, '1},
    '{64'h00000013_002081b3, 30'd86, BTB_NONE, '0, '0, '1, 4'd1, U_ADD, U_NOP, '1, '1},
    '{64'h002081b3_ffffffff, 30'd89, BTB_NONE, '0, '0, '0, '0, U_ADD, U_NOP, '0, '1},
    '{64'h00000013_002081b3, 30'd90, BTB_FIX, '0, '0, '0, '0, U_ADD, U_NOP, '0, '0}
};

`endif

//--- tb_decode_top.sv
module tb_decode_top;
    timeunit 1ns;
    timeprecision 1ps;
    import decode_pkg::*;
    `include "tb_decode_table.svh"

    localparam int BP_PKTS = 16;
    localparam int WATCHDOG_CYCLES = (NUM_ROWS + BP_PKTS + 10) * 20;

    logic            cpu_clk_i;
    logic            rst_n_i;
    logic            flush_i;
    logic            priv_m_i;
    logic            tw_i;
    logic            icache_idle_i;
    logic            fetch_valid_i;
    fetch_packet_t   fetch_pkt_i;
    logic            busy_o;
    logic            rn_busy_i;
    logic            valid_o;
    uop_t            ins0_o;
    uop_t            ins1_o;
    bundle_info_t    bundle_o;
    logic            branch_correction_flush_o;
    logic [PC_W-1:0] branch_correction_pc_o;
    int              errors = 0;
    int              checks = 0;
    int              seed = 32'h8a95_efad;

    decode_top dut (
        .cpu_clk_i (cpu_clk_i), .rst_n_i (rst_n_i), .flush_i (flush_i),
        .priv_m_i (priv_m_i), .tw_i (tw_i), .icache_idle_i (icache_idle_i),
        .fetch_valid_i (fetch_valid_i), .fetch_pkt_i (fetch_pkt_i), .busy_o (busy_o),
        .rn_busy_i (rn_busy_i), .valid_o (valid_o), .ins0_o (ins0_o), .ins1_o (ins1_o),
        .bundle_o (bundle_o), .branch_correction_flush_o (branch_correction_flush_o),
        .branch_correction_pc_o (branch_correction_pc_o)
    );

    initial begin
        cpu_clk_i = 1'b0;
        forever #50 cpu_clk_i = ~cpu_clk_i;
    end

    initial begin
        #(WATCHDOG_CYCLES * 100);
        $display("watchdog expired, the run did not finish in time");
        $display("tests failed");
        $finish;
    end

    task automatic check_uop(input string what, input uop_t got, input uop_t exp);
        checks++;
        if (!exp.excp_valid) got.excp_code = exp.excp_code;  // code only means something on a trap
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bundle(input string what, input bundle_info_t got,
                                input bundle_info_t exp, input logic got_v, input logic exp_v);
        checks++;
        if (got !== exp || got_v !== exp_v) begin
            errors++;
            $display("** Error @ %0t ns: %s got %h/%b expected %h/%b", $time, what,
                     got, got_v, exp, exp_v);
        end
    endtask

    task automatic check_correction(input string what, input logic got_f, input logic exp_f,
                                    input logic [PC_W-1:0] got_pc, input logic [PC_W-1:0] exp_pc);
        checks++;
        if (got_f !== exp_f || (exp_f && got_pc !== exp_pc)) begin
            errors++;
            $display("** Error @ %0t ns: %s flush %b pc %0d expected %b pc %0d", $time, what,
                     got_f, got_pc, exp_f, exp_pc);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error @ %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int start);
        $display("test %s: %s", name, (errors == start) ? "ok" : "FAILED");
    endtask

    // one packet, then sample two edges after the accepting edge
    task automatic send_packet(input fetch_packet_t pkt, input logic priv, input logic tw);
        @(posedge cpu_clk_i);
        fetch_valid_i <= 1'b1;
        fetch_pkt_i   <= pkt;
        priv_m_i      <= priv;
        tw_i          <= tw;
        @(posedge cpu_clk_i);
        fetch_valid_i <= 1'b0;
        @(posedge cpu_clk_i);
        @(negedge cpu_clk_i);
    endtask

    task automatic run_correction(input logic [PC_W-1:0] pc);
        int n;
        send_packet('{NOP_PAIR, pc + PC_W'(2), BTB_NONE, 1'b0, 4'd0}, 1'b0, 1'b0);
        check_flag("bundle behind a held correction", valid_o, 1'b0);
        check_correction("flush before icache idle", branch_correction_flush_o, 1'b0, '0, '0);
        @(posedge cpu_clk_i);
        icache_idle_i <= 1'b1;
        n = 0;
        do begin
            @(negedge cpu_clk_i);
            n++;
        end while (!branch_correction_flush_o && n < 10);
        check_correction("correction flush", branch_correction_flush_o, 1'b1,
                         branch_correction_pc_o, pc);
        @(posedge cpu_clk_i);
        icache_idle_i <= 1'b0;
        @(negedge cpu_clk_i);
        check_correction("hold released", branch_correction_flush_o, 1'b0, '0, '0);
    endtask

    initial begin
        uop_t         exp0;
        uop_t         exp1;
        uop_t         snap0;
        bundle_info_t snap;
        int           start;
        int           sent;
        int           got;
        int           cyc;
        int           r;
        int           occ;
        logic         have_snap;
        logic         acc;

        rst_n_i = 1'b0;
        flush_i = 1'b0;
        priv_m_i = 1'b0;
        tw_i = 1'b0;
        icache_idle_i = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_pkt_i = '0;
        rn_busy_i = 1'b0;
        repeat (10) @(posedge cpu_clk_i);
        rst_n_i <= 1'b1;
        @(negedge cpu_clk_i);
        start = errors;
        check_flag("valid after reset", valid_o, 1'b0);
        check_flag("busy after reset", busy_o, 1'b0);
        check_correction("flush after reset", branch_correction_flush_o, 1'b0, '0, '0);
        report_test("reset", start);

        for (int i = 0; i < NUM_ROWS; i++) begin
            start = errors;
            send_packet('{rows[i].insn, rows[i].pc, rows[i].btb, rows[i].fx_vld, rows[i].fx_code},
                        rows[i].priv_m, rows[i].tw);
            exp0 = rows[i].exp0;
            exp1 = rows[i].exp1;
            if (rows[i].fx_vld) begin  // fetch fault wins on both slots
                exp0.excp_valid = 1'b1;
                exp0.excp_code  = rows[i].fx_code;
                exp1.excp_valid = 1'b1;
                exp1.excp_code  = rows[i].fx_code;
            end
            check_bundle("bundle", bundle_o, '{rows[i].pc, rows[i].btb, rows[i].exp_s1v},
                         valid_o, rows[i].exp_valid);
            check_flag("busy with one packet", busy_o, 1'b0);
            if (rows[i].exp_valid) begin
                check_uop("slot 0", ins0_o, exp0);
                if (rows[i].exp_s1v) check_uop("slot 1", ins1_o, exp1);
            end else begin
                run_correction(rows[i].pc);
            end
            report_test($sformatf("row %0d", i), start);
        end

        start = errors;
        sent = 0;
        got = 0;
        cyc = 0;
        occ = 0;
        have_snap = 1'b0;
        while (got < BP_PKTS && cyc < BP_PKTS * 12) begin
            @(negedge cpu_clk_i);
            cyc++;
            check_flag("busy with two waiting", busy_o, occ == 2);
            if (have_snap) begin
                check_bundle("held bundle", bundle_o, snap, valid_o, 1'b1);
                check_uop("held slot 0", ins0_o, snap0);
            end
            have_snap = valid_o && rn_busy_i;
            snap = bundle_o;
            snap0 = ins0_o;
            if (valid_o && !rn_busy_i) begin  // rename takes it at the next edge
                check_bundle("bundle order", bundle_o, '{PC_W'(200 + 2 * got), BTB_NONE, 1'b1},
                             valid_o, 1'b1);
                got++;
            end
            acc = fetch_valid_i && !busy_o;
            if (occ > 0 && !rn_busy_i) occ--;  // oldest entry moves to the bundle register
            if (acc) occ++;
            @(posedge cpu_clk_i);
            if (acc) sent++;
            fetch_valid_i <= sent < BP_PKTS;
            fetch_pkt_i <= '{NOP_PAIR, PC_W'(200 + 2 * sent), BTB_NONE, 1'b0, 4'd0};
            r = $random(seed);
            rn_busy_i <= r[0];
        end
        fetch_valid_i <= 1'b0;
        rn_busy_i <= 1'b0;
        if (got != BP_PKTS) begin
            errors++;
            $display("back-pressure run stalled with %0d of %0d bundles out", got, BP_PKTS);
        end
        report_test("back-pressure", start);

        start = errors;
        @(posedge cpu_clk_i);
        fetch_valid_i <= 1'b1;
        fetch_pkt_i <= '{rows[0].insn, rows[0].pc, BTB_NONE, 1'b0, 4'd0};
        @(posedge cpu_clk_i);
        fetch_valid_i <= 1'b0;
        @(posedge cpu_clk_i);
        rn_busy_i <= 1'b1;  // bundle would stay on the outputs without the flush
        flush_i <= 1'b1;
        @(negedge cpu_clk_i);
        check_flag("valid before flush", valid_o, 1'b1);
        @(negedge cpu_clk_i);
        check_flag("valid cleared by flush", valid_o, 1'b0);
        @(posedge cpu_clk_i);
        flush_i <= 1'b0;
        rn_busy_i <= 1'b0;
        send_packet('{rows[13].insn, rows[13].pc, BTB_FIX, 1'b0, 4'd0}, 1'b0, 1'b0);
        @(posedge cpu_clk_i);
        fetch_valid_i <= 1'b1;
        fetch_pkt_i <= '{rows[0].insn, rows[0].pc, BTB_NONE, 1'b0, 4'd0};
        @(posedge cpu_clk_i);
        fetch_valid_i <= 1'b0;
        flush_i <= 1'b1;
        icache_idle_i <= 1'b1;
        @(negedge cpu_clk_i);
        check_correction("correction under flush", branch_correction_flush_o, 1'b0, '0, '0);
        @(posedge cpu_clk_i);
        flush_i <= 1'b0;
        @(negedge cpu_clk_i);
        check_correction("pending correction after flush", branch_correction_flush_o, 1'b0,
                         '0, '0);
        @(posedge cpu_clk_i);
        icache_idle_i <= 1'b0;
        send_packet('{rows[0].insn, rows[0].pc, BTB_NONE, 1'b0, 4'd0}, 1'b0, 1'b0);
        check_bundle("bundle after flush", bundle_o, '{rows[0].pc, BTB_NONE, 1'b1}, valid_o, 1'b1);
        check_uop("slot 0 after flush", ins0_o, U_ADD);
        report_test("flush", start);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
